//--- build.f
verilog/csrBusPkg.sv
verilog/videoTimingPkg.sv
verilog/axisTimingIf.sv
verilog/pixelGenCsr.sv
verilog/lineCounter.sv
verilog/frameCounter.sv
verilog/syncCombiner.sv
verilog/pixelGenTop.sv
testbench/pixelGenTb.sv

//--- runSim.sh
#!/bin/sh
# build the pixel generator testbench with Verilator, run it, look for the pass line
cd "$(dirname "$0")" \
	&& verilator --binary --timing --assert --top-module pixelGenTb -f build.f \
	&& ./obj_dir/VpixelGenTb | tee /dev/stderr | grep -q "sim passed" \
	&& echo "simulation ok" \
	|| { echo "simulation not ok"; exit 1; }

//--- testbench/pixelGenStim.txt
# W adrs data : bus write, hex | R adrs valid data : read, valid 0 means no response, hex
# M hPer hPulse hDisp vPer vPulse vDisp : one frame measured, decimal | F n : skip n frames
R 0504 1 00000010
R 0508 1 00000003
R 050C 1 00000002
R 0510 1 00000004
R 0514 1 00000006
R 0518 1 00000001
R 051C 1 00000002
R 0520 1 00000002
R 0580 1 00000012
R 0584 1 00000015
R 0588 1 00000018
R 058C 1 00000007
R 0590 1 00000008
R 0594 1 0000000A
M 25 4 16 11 2 6
# foreign block and holes inside the block
W 0604 00000040
W 0614 00000020
R 0604 0 00000000
R 0504 1 00000010
R 0514 1 00000006
R 0500 1 00000000
R 0524 1 00000000
# new timing, written so each sum only grows
W 0504 00000014
W 050C 00000003
W 0510 00000005
W 0508 00000004
W 0514 00000008
W 0518 00000002
W 0520 00000003
W 051C 00000003
F 2
R 0504 1 00000014
R 0508 1 00000004
R 050C 1 00000003
R 0510 1 00000005
R 0514 1 00000008
R 0518 1 00000002
R 051C 1 00000003
R 0520 1 00000003
R 0580 1 00000017
R 0584 1 0000001B
R 0588 1 0000001F
R 058C 1 0000000A
R 0590 1 0000000C
R 0594 1 0000000F
M 32 5 20 16 3 8

//--- testbench/pixelGenTb.sv
/* pixel generator testbench
   runs bus and frame commands from the stim file against the timing top */
`default_nettype none
`timescale 1ns/10ps

module pixelGenTb
	import csrBusPkg::*, videoTimingPkg::*;
();
	localparam int frameTimeout = 4000;   // cycles, keeps every count inside 12 bits

	logic     iSysClk;
	logic     arstN;
	logic     wrEn;
	logic     rdEn;
	csrAdrs_t adrs;
	csrData_t wrData;
	csrData_t rdData;
	logic     rdValid;
	logic     hSync;
	logic     vSync;
	logic     dataEn;
	hPos_t    pixelX;
	vPos_t    pixelY;

	pixelGenTop u_pixelGenTop (
		.iSysClk(iSysClk), .arstN(arstN),
		.wrEn(wrEn), .rdEn(rdEn), .adrs(adrs), .wrData(wrData),
		.rdData(rdData), .rdValid(rdValid),
		.hSync(hSync), .vSync(vSync), .dataEn(dataEn),
		.pixelX(pixelX), .pixelY(pixelY)
	);

	always #50 iSysClk = ~iSysClk;   // 100 ns period

	// -------------------- reporting
	task automatic abortRun(input string msg);
		begin
			$display("%s", msg);
			$display("sim failed");
			$fatal(1);
		end
	endtask

	task automatic checkData(input csrData_t got, input csrData_t exp, input string what);
		begin
			if (got !== exp)
				abortRun($sformatf("MISMATCH at %0d ns: %s got %h expected %h",
					$time, what, got, exp));
		end
	endtask

	task automatic checkCount(input hCount_t got, input hCount_t exp, input string what);
		begin
			if (got !== exp)
				abortRun($sformatf("MISMATCH at %0d ns: %s got %0d expected %0d",
					$time, what, got, exp));
		end
	endtask

	task automatic checkFlag(input logic got, input logic exp, input string what);
		begin
			if (got !== exp)
				abortRun($sformatf("MISMATCH at %0d ns: %s got %b expected %b",
					$time, what, got, exp));
		end
	endtask

	// -------------------- bus
	task automatic busWrite(input csrAdrs_t a, input csrData_t d);
		begin
			@(negedge iSysClk);
			adrs   = a;
			wrData = d;
			wrEn   = 1'b1;
			@(negedge iSysClk);
			wrEn = 1'b0;
		end
	endtask

	// data and valid land exactly one cycle after the strobe
	task automatic busRead(input csrAdrs_t a, input logic expValid, input csrData_t exp);
		begin
			@(negedge iSysClk);
			adrs = a;
			rdEn = 1'b1;
			@(negedge iSysClk);
			rdEn = 1'b0;
			checkFlag(rdValid, expValid, $sformatf("rdValid after read of %h", a));
			if (expValid)
				checkData(rdData, exp, $sformatf("read data of %h", a));
			@(negedge iSysClk);
			checkFlag(rdValid, 1'b0, $sformatf("rdValid second cycle after read of %h", a));
		end
	endtask

	// -------------------- frame timing
	task automatic waitVSyncFall();
		int   waited;
		logic prevV;
		begin
			waited = 0;
			prevV  = vSync;
			@(negedge iSysClk);
			while (!(prevV && !vSync))
			begin
				waited++;
				if (waited > frameTimeout)
					abortRun("no falling edge on vSync before the frame timeout");
				prevV = vSync;
				@(negedge iSysClk);
			end
		end
	endtask

	// one vSync fall to the next, every line checked on the way
	task automatic measureFrame(input hCount_t hPer, input hCount_t hPulse,
		input hCount_t hDisp, input vCount_t vPer, input vCount_t vPulse, input vCount_t vDisp);
		int   cycles;
		int   sinceHFall;
		int   hLow;
		int   vLow;
		int   lineDe;
		int   activeLines;
		bit   seenHFall;
		bit   done;
		logic prevH;
		logic prevV;
		logic prevDe;
		begin
			waitVSyncFall();
			cycles      = 0;
			sinceHFall  = 0;
			hLow        = 0;
			vLow        = 1;        // the fall sample is already low
			lineDe      = 0;
			activeLines = 0;
			seenHFall   = 1'b0;
			done        = 1'b0;
			prevH       = hSync;
			prevV       = vSync;
			prevDe      = dataEn;
			while (!done)
			begin
				@(negedge iSysClk);
				cycles++;
				sinceHFall++;
				if (cycles > frameTimeout)
					abortRun("frame measurement ran past the frame timeout");
				// horizontal period and pulse
				if (prevH && !hSync)
				begin
					if (seenHFall)
						checkCount(hCount_t'(sinceHFall), hPer, "hSync period");
					seenHFall  = 1'b1;
					sinceHFall = 0;
					hLow       = 0;
				end
				if (!hSync)
					hLow++;
				if (!prevH && hSync && seenHFall)
					checkCount(hCount_t'(hLow), hPulse, "hSync low cycles");
				// vertical pulse in cycles
				if (!vSync)
					vLow++;
				if (!prevV && vSync)
					checkCount(hCount_t'(vLow), hCount_t'(int'(vPulse) * int'(hPer)),
						"vSync low cycles");
				// active area and coordinates
				if (!prevDe && dataEn)
					lineDe = 0;
				if (dataEn)
				begin
					checkCount(hCount_t'(pixelX), hCount_t'(lineDe), "pixelX");
					checkCount(hCount_t'(pixelY), hCount_t'(activeLines), "pixelY");
					lineDe++;
				end
				if (prevDe && !dataEn)
				begin
					checkCount(hCount_t'(lineDe), hDisp, "dataEn cycles per line");
					activeLines++;
				end
				if (prevV && !vSync)
				begin
					checkCount(hCount_t'(cycles), hCount_t'(int'(vPer) * int'(hPer)),
						"vSync period");
					checkCount(hCount_t'(activeLines), vDisp, "active lines per frame");
					done = 1'b1;
				end
				prevH  = hSync;
				prevV  = vSync;
				prevDe = dataEn;
			end
		end
	endtask

	// -------------------- stim interpreter
	initial
	begin
		int          fd;
		int          fields;
		int          frames;
		int          mHPer, mHPulse, mHDisp, mVPer, mVPulse, mVDisp;
		string       line;
		logic [7:0]  cmd;
		csrAdrs_t    a;
		csrData_t    d;
		logic [31:0] valid;
		iSysClk = 1'b0;
		arstN   = 1'b0;
		wrEn    = 1'b0;
		rdEn    = 1'b0;
		adrs    = '0;
		wrData  = '0;
		repeat (16) @(negedge iSysClk);
		arstN = 1'b1;
		checkFlag(rdValid, 1'b0, "rdValid after reset");
		checkFlag(hSync, 1'b1, "hSync after reset");
		checkFlag(vSync, 1'b1, "vSync after reset");
		checkFlag(dataEn, 1'b0, "dataEn after reset");

		fd = $fopen("testbench/pixelGenStim.txt", "r");
		if (fd == 0)
			abortRun("could not open the stim file testbench/pixelGenStim.txt");
		while (!$feof(fd))
		begin
			if ($fgets(line, fd) != 0 && line.len() > 1 && line[0] != "#")
			begin
				cmd = line[0];
				case (cmd)
					"W":
					begin
						fields = $sscanf(line.substr(1, line.len() - 1), "%h %h", a, d);
						if (fields != 2)
							abortRun({"bad write line in stim file: ", line});
						busWrite(a, d);
					end
					"R":
					begin
						fields = $sscanf(line.substr(1, line.len() - 1), "%h %h %h",
							a, valid, d);
						if (fields != 3)
							abortRun({"bad read line in stim file: ", line});
						busRead(a, valid[0], d);
					end
					"M":
					begin
						fields = $sscanf(line.substr(1, line.len() - 1), "%d %d %d %d %d %d",
							mHPer, mHPulse, mHDisp, mVPer, mVPulse, mVDisp);
						if (fields != 6)
							abortRun({"bad measure line in stim file: ", line});
						measureFrame(hCount_t'(mHPer), hCount_t'(mHPulse), hCount_t'(mHDisp),
							vCount_t'(mVPer), vCount_t'(mVPulse), vCount_t'(mVDisp));
					end
					"F":
					begin
						fields = $sscanf(line.substr(1, line.len() - 1), "%d", frames);
						if (fields != 1)
							abortRun({"bad frame skip line in stim file: ", line});
						repeat (frames) waitVSyncFall();   // lets new timing settle
					end
					default:
						abortRun({"unknown command in stim file: ", line});
				endcase
			end
		end
		$fclose(fd);
		$display("sim passed");
		$finish;
	end
endmodule

`default_nettype wire

//--- verilog/axisTimingIf.sv
/* axis timing interface
   display size and derived sync points of one axis, from csr to counter */
`default_nettype none
`timescale 1ns/10ps

interface axisTimingIf
	import videoTimingPkg::*;
#(
	parameter int pDispWidth = hDisplayWidth
)();
	logic [pDispWidth-1:0] display;     // visible pixels or lines
	logic [pDispWidth:0]   syncStart;   // first count of sync pulse
	logic [pDispWidth:0]   syncEnd;     // last count of sync pulse
	logic [pDispWidth:0]   syncMax;     // last count of the period

	// -------------------- csr side drives
	modport csr (
		output display, syncStart, syncEnd, syncMax
	);

	// -------------------- counter side reads
	modport counter (
		input display, syncStart, syncEnd, syncMax
	);
endinterface

`default_nettype wire

//--- verilog/csrBusPkg.sv
/* csr bus package
   bus widths, address split and register offsets of the pixel generator */
`default_nettype none

package csrBusPkg;
	localparam int csrAdrsWidth    = 16;
	localparam int csrDataWidth    = 32;
	localparam int blockFieldWidth = 8;                              // upper address bits
	localparam int regOfsWidth     = csrAdrsWidth - blockFieldWidth; // lower address bits

	typedef logic [csrAdrsWidth-1:0]    csrAdrs_t;
	typedef logic [csrDataWidth-1:0]    csrData_t;
	typedef logic [blockFieldWidth-1:0] blockField_t;
	typedef logic [regOfsWidth-1:0]     regOfs_t;

	// -------------------- writable timing
	localparam regOfs_t REG_HDISPLAY   = 8'h04;
	localparam regOfs_t REG_HBACK      = 8'h08;
	localparam regOfs_t REG_HFRONT     = 8'h0C;
	localparam regOfs_t REG_HPULSE     = 8'h10;
	localparam regOfs_t REG_VDISPLAY   = 8'h14;
	localparam regOfs_t REG_VFRONT     = 8'h18;
	localparam regOfs_t REG_VBACK      = 8'h1C;
	localparam regOfs_t REG_VPULSE     = 8'h20;
	// -------------------- derived, read only
	localparam regOfs_t REG_HSYNCSTART = 8'h80;
	localparam regOfs_t REG_HSYNCEND   = 8'h84;
	localparam regOfs_t REG_HSYNCMAX   = 8'h88;
	localparam regOfs_t REG_VSYNCSTART = 8'h8C;
	localparam regOfs_t REG_VSYNCEND   = 8'h90;
	localparam regOfs_t REG_VSYNCMAX   = 8'h94;
endpackage

`default_nettype wire

//--- verilog/frameCounter.sv
/* frame counter
   line count per frame, stepped by line-end, with vertical flags */
`default_nettype none
`timescale 1ns/10ps

module frameCounter
	import videoTimingPkg::*;
(
	input  logic         iSysClk,
	input  logic         arstN,
	axisTimingIf.counter vTiming,
	input  logic         lineEnd,
	output vCount_t      vCount,
	output logic         vActive,
	output logic         vSyncActive
);
	logic frameEnd;

	// last pixel of the last line
	assign frameEnd = lineEnd && (vCount == vTiming.syncMax);

	// -------------------- line count
	always_ff @(posedge iSysClk or negedge arstN)
	begin
		if (!arstN)
		begin
			vCount <= '0;
		end
		else if (frameEnd)
		begin
			vCount <= '0;
		end
		else if (lineEnd)
		begin
			vCount <= vCount + vCount_t'(1);   // wraps at width on a lowered max
		end
	end

	// -------------------- flags
	// follow vCount, so they only move right after a line end
	assign vActive     = vCount < vCount_t'(vTiming.display);
	assign vSyncActive = (vCount >= vTiming.syncStart)
		&& (vCount <= vTiming.syncEnd);
endmodule

`default_nettype wire

//--- verilog/lineCounter.sv
/* line counter
   free-running pixel count per line with line-end strobe and horizontal flags */
`default_nettype none
`timescale 1ns/10ps

module lineCounter
	import videoTimingPkg::*;
(
	input  logic         iSysClk,
	input  logic         arstN,
	axisTimingIf.counter hTiming,
	output hCount_t      hCount,
	output logic         lineEnd,
	output logic         hActive,
	output logic         hSyncActive
);
	logic atMax;

	assign atMax = hCount == hTiming.syncMax;

	// -------------------- pixel count
	// a max lowered below the count lets it wrap at full width first
	always_ff @(posedge iSysClk or negedge arstN)
	begin
		if (!arstN)
			hCount <= '0;
		else if (atMax)
			hCount <= '0;
		else
			hCount <= hCount + hCount_t'(1);
	end

	// -------------------- flags
	assign lineEnd     = atMax;                                  // last pixel of the line
	assign hActive     = hCount < hCount_t'(hTiming.display);
	assign hSyncActive = (hCount >= hTiming.syncStart)
		&& (hCount <= hTiming.syncEnd);                          // inclusive window

	// -------------------- checks
	aLineEndPulse: assert property (@(posedge iSysClk) disable iff (!arstN)
		lineEnd |=> !lineEnd);
endmodule

`default_nettype wire

//--- verilog/pixelGenCsr.sv
/* pixel generator csr
   panel timing registers, derived sync sums and strobe bus read-back */
`default_nettype none
`timescale 1ns/10ps

module pixelGenCsr
	import csrBusPkg::*, videoTimingPkg::*;
#(
	parameter blockField_t pBlockAdrs = 8'h05,
	parameter hPos_t       pHdisplay  = 11'd480,
	parameter porch_t      pHfront    = 7'd8,
	parameter porch_t      pHback     = 7'd43,
	parameter porch_t      pHpulse    = 7'd30,
	parameter vPos_t       pVdisplay  = 11'd272,
	parameter porch_t      pVfront    = 7'd12,
	parameter porch_t      pVback     = 7'd4,
	parameter porch_t      pVpulse    = 7'd10
)(
	input  logic     iSysClk,
	input  logic     arstN,
	input  logic     wrEn,
	input  logic     rdEn,
	input  csrAdrs_t adrs,
	input  csrData_t wrData,
	output csrData_t rdData,
	output logic     rdValid,
	axisTimingIf.csr hTiming,
	axisTimingIf.csr vTiming
);
	// derived values right after reset
	localparam hCount_t hStartRst = hCount_t'(pHdisplay) + hCount_t'(pHfront);
	localparam hCount_t hEndRst   = hStartRst + hCount_t'(pHpulse) - hCount_t'(1);
	localparam hCount_t hMaxRst   = hEndRst + hCount_t'(pHback);
	localparam vCount_t vStartRst = vCount_t'(pVdisplay) + vCount_t'(pVfront);
	localparam vCount_t vEndRst   = vStartRst + vCount_t'(pVpulse) - vCount_t'(1);
	localparam vCount_t vMaxRst   = vEndRst + vCount_t'(pVback);

	logic     blockHit;
	regOfs_t  regOfs;
	hPos_t    hDisplay;
	porch_t   hFront, hBack, hPulse;
	vPos_t    vDisplay;
	porch_t   vFront, vBack, vPulse;
	hPos_t    hDisplayQ;                     // display copy, moves with the sums
	hCount_t  hSyncStart, hSyncEnd, hSyncMax;
	vPos_t    vDisplayQ;
	vCount_t  vSyncStart, vSyncEnd, vSyncMax;
	csrData_t rdMux;

	assign blockHit = adrs[csrAdrsWidth-1 -: blockFieldWidth] == pBlockAdrs;
	assign regOfs   = adrs[regOfsWidth-1:0];

	// -------------------- timing registers
	always_ff @(posedge iSysClk or negedge arstN)
	begin
		if (!arstN)
		begin
			hDisplay <= pHdisplay;
			hFront   <= pHfront;
			hBack    <= pHback;
			hPulse   <= pHpulse;
			vDisplay <= pVdisplay;
			vFront   <= pVfront;
			vBack    <= pVback;
			vPulse   <= pVpulse;
		end
		else if (wrEn && blockHit)
		begin
			case (regOfs)
				REG_HDISPLAY: hDisplay <= wrData[hDisplayWidth-1:0];
				REG_HBACK:    hBack    <= wrData[porchWidth-1:0];
				REG_HFRONT:   hFront   <= wrData[porchWidth-1:0];
				REG_HPULSE:   hPulse   <= wrData[porchWidth-1:0];
				REG_VDISPLAY: vDisplay <= wrData[vDisplayWidth-1:0];
				REG_VFRONT:   vFront   <= wrData[porchWidth-1:0];
				REG_VBACK:    vBack    <= wrData[porchWidth-1:0];
				REG_VPULSE:   vPulse   <= wrData[porchWidth-1:0];
				default:      ;            // derived offsets ignore writes
			endcase
		end
	end

	// -------------------- derived sums
	// each sum built straight from the registers, so all land together
	always_ff @(posedge iSysClk or negedge arstN)
	begin
		if (!arstN)
		begin
			hDisplayQ  <= pHdisplay;
			hSyncStart <= hStartRst;
			hSyncEnd   <= hEndRst;
			hSyncMax   <= hMaxRst;
			vDisplayQ  <= pVdisplay;
			vSyncStart <= vStartRst;
			vSyncEnd   <= vEndRst;
			vSyncMax   <= vMaxRst;
		end
		else
		begin
			hDisplayQ  <= hDisplay;
			hSyncStart <= hCount_t'(hDisplay) + hCount_t'(hFront);
			hSyncEnd   <= hCount_t'(hDisplay) + hCount_t'(hFront) + hCount_t'(hPulse)
				- hCount_t'(1);
			hSyncMax   <= hCount_t'(hDisplay) + hCount_t'(hFront) + hCount_t'(hPulse)
				+ hCount_t'(hBack) - hCount_t'(1);
			vDisplayQ  <= vDisplay;
			vSyncStart <= vCount_t'(vDisplay) + vCount_t'(vFront);
			vSyncEnd   <= vCount_t'(vDisplay) + vCount_t'(vFront) + vCount_t'(vPulse)
				- vCount_t'(1);
			vSyncMax   <= vCount_t'(vDisplay) + vCount_t'(vFront) + vCount_t'(vPulse)
				+ vCount_t'(vBack) - vCount_t'(1);
		end
	end

	assign hTiming.display   = hDisplayQ;
	assign hTiming.syncStart = hSyncStart;
	assign hTiming.syncEnd   = hSyncEnd;
	assign hTiming.syncMax   = hSyncMax;
	assign vTiming.display   = vDisplayQ;
	assign vTiming.syncStart = vSyncStart;
	assign vTiming.syncEnd   = vSyncEnd;
	assign vTiming.syncMax   = vSyncMax;

	// -------------------- read back
	always_comb
	begin
		case (regOfs)
			REG_HDISPLAY:   rdMux = csrData_t'(hDisplay);
			REG_HBACK:      rdMux = csrData_t'(hBack);
			REG_HFRONT:     rdMux = csrData_t'(hFront);
			REG_HPULSE:     rdMux = csrData_t'(hPulse);
			REG_VDISPLAY:   rdMux = csrData_t'(vDisplay);
			REG_VFRONT:     rdMux = csrData_t'(vFront);
			REG_VBACK:      rdMux = csrData_t'(vBack);
			REG_VPULSE:     rdMux = csrData_t'(vPulse);
			REG_HSYNCSTART: rdMux = csrData_t'(hSyncStart);
			REG_HSYNCEND:   rdMux = csrData_t'(hSyncEnd);
			REG_HSYNCMAX:   rdMux = csrData_t'(hSyncMax);
			REG_VSYNCSTART: rdMux = csrData_t'(vSyncStart);
			REG_VSYNCEND:   rdMux = csrData_t'(vSyncEnd);
			REG_VSYNCMAX:   rdMux = csrData_t'(vSyncMax);
			default:        rdMux = '0;  // holes in the map
		endcase
	end

	always_ff @(posedge iSysClk or negedge arstN)
	begin
		if (!arstN)
			rdValid <= 1'b0;
		else
			rdValid <= rdEn && blockHit;   // one-cycle pulse per strobe
	end

	always_ff @(posedge iSysClk)
	begin
		if (rdEn && blockHit)
			rdData <= rdMux;
	end

	// -------------------- checks
	aRdValidFromStrobe: assert property (@(posedge iSysClk) disable iff (!arstN)
		rdValid |-> $past(rdEn));
	aHMaxNotBelowDisp: assert property (@(posedge iSysClk) disable iff (!arstN)
		hSyncMax >= hCount_t'(hDisplayQ));
	aVMaxNotBelowDisp: assert property (@(posedge iSysClk) disable iff (!arstN)
		vSyncMax >= vCount_t'(vDisplayQ));
endmodule

`default_nettype wire

//--- verilog/pixelGenTop.sv
/* pixel generator timing top
   csr, line and frame counters and sync combiner behind a strobe bus */
`default_nettype none
`timescale 1ns/10ps

module pixelGenTop
	import csrBusPkg::*, videoTimingPkg::*;
#(
	parameter blockField_t pBlockAdrs = 8'h05,
	parameter hPos_t       pHdisplay  = 11'd16,
	parameter porch_t      pHfront    = 7'd2,
	parameter porch_t      pHback     = 7'd3,
	parameter porch_t      pHpulse    = 7'd4,
	parameter vPos_t       pVdisplay  = 11'd6,
	parameter porch_t      pVfront    = 7'd1,
	parameter porch_t      pVback     = 7'd2,
	parameter porch_t      pVpulse    = 7'd2
)(
	input  logic     iSysClk,
	input  logic     arstN,
	input  logic     wrEn,
	input  logic     rdEn,
	input  csrAdrs_t adrs,
	input  csrData_t wrData,
	output csrData_t rdData,
	output logic     rdValid,
	output logic     hSync,
	output logic     vSync,
	output logic     dataEn,
	output hPos_t    pixelX,
	output vPos_t    pixelY
);
	hCount_t hCount;
	vCount_t vCount;
	logic    lineEnd, hActive, hSyncActive, vActive, vSyncActive;

	// -------------------- per-axis timing
	axisTimingIf #(.pDispWidth(hDisplayWidth)) hTiming ();
	axisTimingIf #(.pDispWidth(vDisplayWidth)) vTiming ();

	pixelGenCsr #(
		.pBlockAdrs(pBlockAdrs),
		.pHdisplay(pHdisplay), .pHfront(pHfront), .pHback(pHback), .pHpulse(pHpulse),
		.pVdisplay(pVdisplay), .pVfront(pVfront), .pVback(pVback), .pVpulse(pVpulse)
	) u_pixelGenCsr (
		.iSysClk(iSysClk), .arstN(arstN),
		.wrEn(wrEn), .rdEn(rdEn), .adrs(adrs), .wrData(wrData),
		.rdData(rdData), .rdValid(rdValid),
		.hTiming(hTiming.csr), .vTiming(vTiming.csr)
	);

	// -------------------- counters
	lineCounter u_lineCounter (
		.iSysClk(iSysClk), .arstN(arstN), .hTiming(hTiming.counter),
		.hCount(hCount), .lineEnd(lineEnd), .hActive(hActive), .hSyncActive(hSyncActive)
	);

	frameCounter u_frameCounter (
		.iSysClk(iSysClk), .arstN(arstN), .vTiming(vTiming.counter), .lineEnd(lineEnd),
		.vCount(vCount), .vActive(vActive), .vSyncActive(vSyncActive)
	);

	syncCombiner u_syncCombiner (
		.iSysClk(iSysClk), .arstN(arstN),
		.hCount(hCount), .vCount(vCount),
		.hActive(hActive), .vActive(vActive),
		.hSyncActive(hSyncActive), .vSyncActive(vSyncActive),
		.hSync(hSync), .vSync(vSync), .dataEn(dataEn),
		.pixelX(pixelX), .pixelY(pixelY)
	);
endmodule

`default_nettype wire

//--- verilog/syncCombiner.sv
/* sync combiner
   registers both axes into active-low syncs, data enable and coordinates */
`default_nettype none
`timescale 1ns/10ps

module syncCombiner
	import videoTimingPkg::*;
(
	input  logic    iSysClk,
	input  logic    arstN,
	input  hCount_t hCount,
	input  vCount_t vCount,
	input  logic    hActive,
	input  logic    vActive,
	input  logic    hSyncActive,
	input  logic    vSyncActive,
	output logic    hSync,
	output logic    vSync,
	output logic    dataEn,
	output hPos_t   pixelX,
	output vPos_t   pixelY
);
	logic inDisplay;

	assign inDisplay = hActive && vActive;   // both axes visible

	// -------------------- output stage
	// one cycle behind the counters
	always_ff @(posedge iSysClk or negedge arstN)
	begin
		if (!arstN)
		begin
			hSync  <= 1'b1;     // idle high
			vSync  <= 1'b1;
			dataEn <= 1'b0;
			pixelX <= '0;
			pixelY <= '0;
		end
		else
		begin
			hSync  <= !hSyncActive;
			vSync  <= !vSyncActive;
			dataEn <= inDisplay;
			if (inDisplay)
			begin
				pixelX <= hCount[hDisplayWidth-1:0];   // count below display fits
				pixelY <= vCount[vDisplayWidth-1:0];
			end
			else
			begin
				pixelX <= '0;
				pixelY <= '0;
			end
		end
	end

	// -------------------- checks
	aPixelXIdle: assert property (@(posedge iSysClk) disable iff (!arstN)
		!dataEn |-> (pixelX == '0));
endmodule

`default_nettype wire

//--- verilog/videoTimingPkg.sv
/* video timing package
   counter widths and per-axis value types of the panel timing */
`default_nettype none

package videoTimingPkg;
	// -------------------- widths
	localparam int hDisplayWidth = 11;
	localparam int vDisplayWidth = 11;
	localparam int porchWidth    = 7;   // front, back and pulse alike

	// -------------------- counts
	// one bit above display so the count can reach the total
	typedef logic [hDisplayWidth:0] hCount_t;
	typedef logic [vDisplayWidth:0] vCount_t;

	// -------------------- coordinates and fields
	typedef logic [hDisplayWidth-1:0] hPos_t;  // pixel x inside display
	typedef logic [vDisplayWidth-1:0] vPos_t;  // pixel y inside display
	typedef logic [porchWidth-1:0]    porch_t;
endpackage

`default_nettype wire
